//--- Bender.yml
package:
  name: rp_core

export_include_dirs:
  - include

sources:
  - hw/rp_pkg.sv
  - hw/rp_sys_bus_mux.sv
  - hw/rp_housekeeping.sv
  - hw/rp_dc_gen.sv
  - hw/rp_adc_frontend.sv
  - hw/rp_dac_backend.sv
  - hw/rp_top.sv
  - target: simulation
    files:
      - testbench/tb_rp_top.sv

//--- hw/rp_adc_frontend.sv
/*
 * ADC front end
 * registers both channels, turns the unsigned
 * negative slope code into two's complement and
 * swaps in the DAC value under digital loop
 */

`timescale 1ns/10ps
`default_nettype none

`include "rp_defs.svh"

module rp_adc_frontend (
  input  wire                     adc_clk,
  input  wire                     rst_n_i,
  input  wire [`RP_ADC_PIN_W-1:0] adc_dat_a_i,
  input  wire [`RP_ADC_PIN_W-1:0] adc_dat_b_i,
  input  wire                     digital_loop_i,
  input  wire rp_pkg::smp_t       loop_a_i,      // registered DAC value
  input  wire rp_pkg::smp_t       loop_b_i,
  output rp_pkg::smp_t            adc_a_o,
  output rp_pkg::smp_t            adc_b_o
);

  localparam int PIN_LO = `RP_ADC_PIN_W - `RP_SMP_W;  // low pin bits unused

  logic [`RP_SMP_W-1:0] adc_dat_a;  // raw pin code
  logic [`RP_SMP_W-1:0] adc_dat_b;

  // input registers, ideally packed into the IOBs
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      adc_dat_a <= '0;
      adc_dat_b <= '0;
    end
    else
    begin
      adc_dat_a <= adc_dat_a_i[`RP_ADC_PIN_W-1:PIN_LO];
      adc_dat_b <= adc_dat_b_i[`RP_ADC_PIN_W-1:PIN_LO];
    end
  end

  // neg slope -> 2's complement, or loopback
  assign adc_a_o = digital_loop_i ? loop_a_i : rp_pkg::smp_t'(rp_pkg::nslope(adc_dat_a));
  assign adc_b_o = digital_loop_i ? loop_b_i : rp_pkg::smp_t'(rp_pkg::nslope(adc_dat_b));

endmodule

`default_nettype wire

//--- hw/rp_dac_backend.sv
/*
 * DAC back end
 * level plus gated sample per channel, saturated to
 * 14 bits, registered, then back to negative slope code
 */

`timescale 1ns/10ps
`default_nettype none

`include "rp_defs.svh"

module rp_dac_backend (
  input  wire                  adc_clk,
  input  wire                  rst_n_i,
  input  wire rp_pkg::smp_t    level_a_i,
  input  wire rp_pkg::smp_t    level_b_i,
  input  wire rp_pkg::smp_t    adc_a_i,
  input  wire rp_pkg::smp_t    adc_b_i,
  input  wire [1:0]            fb_en_i,
  output logic [`RP_SMP_W-1:0] dac_dat_a_o,  // pin code
  output logic [`RP_SMP_W-1:0] dac_dat_b_o,
  output rp_pkg::smp_t         dac_a_o,      // registered signed value
  output rp_pkg::smp_t         dac_b_o
);

  rp_pkg::smp_t              lvl  [2];
  rp_pkg::smp_t              smp  [2];
  rp_pkg::smp_t              gate [2];  // second summand
  logic signed [`RP_SMP_W:0] sum  [2];  // one guard bit
  rp_pkg::smp_t              sat  [2];
  rp_pkg::smp_t              dac  [2];

  assign lvl[0] = level_a_i;
  assign lvl[1] = level_b_i;
  assign smp[0] = adc_a_i;
  assign smp[1] = adc_b_i;

  ////////////////////
  // sum + saturation
  ////////////////////

  always_comb
  begin
    for (int ch = 0; ch < 2; ch++)
    begin
      gate[ch] = fb_en_i[ch] ? smp[ch] : rp_pkg::smp_t'(0);
      sum[ch]  = lvl[ch] + gate[ch];
      // top two bits differ -> overflow, clip to the sign's limit
      if (sum[ch][`RP_SMP_W] ^ sum[ch][`RP_SMP_W-1])
        sat[ch] = {sum[ch][`RP_SMP_W], {(`RP_SMP_W-1){~sum[ch][`RP_SMP_W]}}};
      else
        sat[ch] = sum[ch][`RP_SMP_W-1:0];
    end
  end

  // output register, zero after reset
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      dac[0] <= '0;
      dac[1] <= '0;
    end
    else
    begin
      dac[0] <= sat[0];
      dac[1] <= sat[1];
    end
  end

  assign dac_a_o = dac[0];
  assign dac_b_o = dac[1];

  // signed -> pin code (neg slope)
  assign dac_dat_a_o = rp_pkg::nslope(dac[0]);
  assign dac_dat_b_o = rp_pkg::nslope(dac[1]);

endmodule

`default_nettype wire

//--- hw/rp_dc_gen.sv
/*
 * DC level generator, bus region 2
 * per channel signed level and feedback enable
 */

`timescale 1ns/10ps
`default_nettype none

`include "rp_defs.svh"

module rp_dc_gen (
  input  wire                    adc_clk,
  input  wire                    rst_n_i,
  input  wire rp_pkg::bus_word_t sys_addr_i,
  input  wire rp_pkg::bus_word_t sys_wdata_i,
  input  wire                    sys_wen_i,
  input  wire                    sys_ren_i,
  output rp_pkg::bus_word_t      sys_rdata_o,
  output logic                   sys_ack_o,
  output rp_pkg::smp_t           level_a_o,
  output rp_pkg::smp_t           level_b_o,
  output logic [1:0]             fb_en_o     // [0] ch a, [1] ch b
);

  localparam int EXT_W = `RP_BUS_W - `RP_SMP_W;  // sign extension on readback

  logic [`RP_REG_SEL_LO-1:0] ofs;

  assign ofs = sys_addr_i[`RP_REG_SEL_LO-1:0];

  // level / enable registers
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      level_a_o <= '0;
      level_b_o <= '0;
      fb_en_o   <= '0;  // no feedback after reset
    end
    else if (sys_wen_i)
    begin
      case (ofs)
        `RP_DCG_LVL_A_OFS : level_a_o <= sys_wdata_i[`RP_SMP_W-1:0];
        `RP_DCG_LVL_B_OFS : level_b_o <= sys_wdata_i[`RP_SMP_W-1:0];
        `RP_DCG_FB_EN_OFS : fb_en_o   <= sys_wdata_i[1:0];
        default           : ;
      endcase
    end
  end

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      sys_ack_o <= 1'b0;
    else
      sys_ack_o <= sys_wen_i | sys_ren_i;  // one cycle late
  end

  // readback, levels sign extended
  always_ff @(posedge adc_clk)
  begin
    if (sys_ren_i)
    begin
      case (ofs)
        `RP_DCG_LVL_A_OFS : sys_rdata_o <= {{EXT_W{level_a_o[`RP_SMP_W-1]}}, level_a_o};
        `RP_DCG_LVL_B_OFS : sys_rdata_o <= {{EXT_W{level_b_o[`RP_SMP_W-1]}}, level_b_o};
        `RP_DCG_FB_EN_OFS : sys_rdata_o <= rp_pkg::bus_word_t'(fb_en_o);
        default           : sys_rdata_o <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/rp_housekeeping.sv
/*
 * Housekeeping registers, bus region 0
 * ID word, digital loop flag, LEDs and the expansion
 * connector direction / output / input registers
 */

`timescale 1ns/10ps
`default_nettype none

`include "rp_defs.svh"

module rp_housekeeping (
  input  wire                      adc_clk,
  input  wire                      rst_n_i,
  input  wire rp_pkg::bus_word_t   sys_addr_i,
  input  wire rp_pkg::bus_word_t   sys_wdata_i,
  input  wire                      sys_wen_i,
  input  wire                      sys_ren_i,
  input  wire [`RP_EXP_W-1:0]      exp_p_dat_i,
  input  wire [`RP_EXP_W-1:0]      exp_n_dat_i,
  output rp_pkg::bus_word_t        sys_rdata_o,
  output logic                     sys_ack_o,
  output logic [`RP_LED_W-1:0]     led_o,
  output logic [`RP_EXP_W-1:0]     exp_p_dat_o,
  output logic [`RP_EXP_W-1:0]     exp_n_dat_o,
  output logic [`RP_EXP_W-1:0]     exp_p_dir_o,  // 1 = drive
  output logic [`RP_EXP_W-1:0]     exp_n_dir_o,
  output logic                     digital_loop_o
);

  logic [`RP_REG_SEL_LO-1:0] ofs;  // offset within region

  assign ofs = sys_addr_i[`RP_REG_SEL_LO-1:0];

  ////////////////////
  // write
  ////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      digital_loop_o <= 1'b0;
      led_o          <= '0;
      exp_p_dir_o    <= '0;  // all inputs after reset
      exp_n_dir_o    <= '0;
      exp_p_dat_o    <= '0;
      exp_n_dat_o    <= '0;
    end
    else if (sys_wen_i)
    begin
      case (ofs)
        `RP_HK_DLOOP_OFS     : digital_loop_o <= sys_wdata_i[0];
        `RP_HK_EXP_P_DIR_OFS : exp_p_dir_o    <= sys_wdata_i[`RP_EXP_W-1:0];
        `RP_HK_EXP_N_DIR_OFS : exp_n_dir_o    <= sys_wdata_i[`RP_EXP_W-1:0];
        `RP_HK_EXP_P_OUT_OFS : exp_p_dat_o    <= sys_wdata_i[`RP_EXP_W-1:0];
        `RP_HK_EXP_N_OUT_OFS : exp_n_dat_o    <= sys_wdata_i[`RP_EXP_W-1:0];
        `RP_HK_LED_OFS       : led_o          <= sys_wdata_i[`RP_LED_W-1:0];
        default              : ;  // id and inputs are read only
      endcase
    end
  end

  ////////////////////
  // read / ack
  ////////////////////

  // one cycle after the pulse
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      sys_ack_o <= 1'b0;
    else
      sys_ack_o <= sys_wen_i | sys_ren_i;
  end

  always_ff @(posedge adc_clk)
  begin
    if (sys_ren_i)
    begin
      case (ofs)
        `RP_HK_ID_OFS        : sys_rdata_o <= `RP_HK_ID;
        `RP_HK_DLOOP_OFS     : sys_rdata_o <= rp_pkg::bus_word_t'(digital_loop_o);
        `RP_HK_EXP_P_DIR_OFS : sys_rdata_o <= rp_pkg::bus_word_t'(exp_p_dir_o);
        `RP_HK_EXP_N_DIR_OFS : sys_rdata_o <= rp_pkg::bus_word_t'(exp_n_dir_o);
        `RP_HK_EXP_P_OUT_OFS : sys_rdata_o <= rp_pkg::bus_word_t'(exp_p_dat_o);
        `RP_HK_EXP_N_OUT_OFS : sys_rdata_o <= rp_pkg::bus_word_t'(exp_n_dat_o);
        `RP_HK_EXP_P_IN_OFS  : sys_rdata_o <= rp_pkg::bus_word_t'(exp_p_dat_i);  // live pins
        `RP_HK_EXP_N_IN_OFS  : sys_rdata_o <= rp_pkg::bus_word_t'(exp_n_dat_i);
        `RP_HK_LED_OFS       : sys_rdata_o <= rp_pkg::bus_word_t'(led_o);
        default              : sys_rdata_o <= '0;  // unmapped
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/rp_pkg.sv
/*
 * Shared types of the analog core
 * samples, bus words, region selects and the
 * negative slope code flip used on both converters
 */

`default_nettype none

`include "rp_defs.svh"

package rp_pkg;

  typedef logic signed [`RP_SMP_W-1:0]                    smp_t;        // two's complement sample
  typedef logic        [`RP_BUS_W-1:0]                    bus_word_t;
  typedef logic        [`RP_REG_SEL_HI-`RP_REG_SEL_LO:0]  region_t;     // region index
  typedef logic        [`RP_REGIONS-1:0]                  region_vec_t; // one bit per region

  // keep msb, invert the rest; works both ways
  function automatic logic [`RP_SMP_W-1:0] nslope(input logic [`RP_SMP_W-1:0] code);
    return {code[`RP_SMP_W-1], ~code[`RP_SMP_W-2:0]};
  endfunction

endpackage

`default_nettype wire

//--- hw/rp_sys_bus_mux.sv
/*
 * System bus decoder
 * splits the address space into 8 regions on addr[22:20],
 * steers wen/ren pulses and returns rdata/ack/err of the
 * selected region; unused regions answer right here
 */

`timescale 1ns/10ps
`default_nettype none

`include "rp_defs.svh"

module rp_sys_bus_mux (
  input  wire rp_pkg::bus_word_t sys_addr_i,
  input  wire                    sys_wen_i,   // one cycle pulse
  input  wire                    sys_ren_i,   // one cycle pulse
  input  wire rp_pkg::bus_word_t hk_rdata_i,
  input  wire rp_pkg::bus_word_t dcg_rdata_i,
  input  wire                    hk_ack_i,
  input  wire                    dcg_ack_i,
  output logic                   hk_wen_o,
  output logic                   hk_ren_o,
  output logic                   dcg_wen_o,
  output logic                   dcg_ren_o,
  output rp_pkg::bus_word_t      sys_rdata_o,
  output logic                   sys_ack_o,
  output logic                   sys_err_o
);

  localparam int HK_REG  = 0;  // housekeeping
  localparam int DCG_REG = 2;  // dc level generator

  rp_pkg::region_t     region;
  rp_pkg::region_vec_t cs;                       // one-hot select
  rp_pkg::bus_word_t   rdata_vec [`RP_REGIONS];
  rp_pkg::region_vec_t ack_vec;
  rp_pkg::region_vec_t err_vec;

  ////////////////////
  // decode
  ////////////////////

  assign region = sys_addr_i[`RP_REG_SEL_HI:`RP_REG_SEL_LO];
  assign cs     = rp_pkg::region_vec_t'(1) << region;

  assign hk_wen_o  = cs[HK_REG]  & sys_wen_i;
  assign hk_ren_o  = cs[HK_REG]  & sys_ren_i;
  assign dcg_wen_o = cs[DCG_REG] & sys_wen_i;
  assign dcg_ren_o = cs[DCG_REG] & sys_ren_i;

  ////////////////////
  // response mux
  ////////////////////

  always_comb
  begin
    // idle regions: zero data, ack with the pulse, never err
    for (int r = 0; r < `RP_REGIONS; r++)
    begin
      rdata_vec[r] = '0;
      ack_vec[r]   = sys_wen_i | sys_ren_i;
      err_vec[r]   = 1'b0;
    end
    rdata_vec[HK_REG]  = hk_rdata_i;
    ack_vec[HK_REG]    = hk_ack_i;    // registered in the slave
    rdata_vec[DCG_REG] = dcg_rdata_i;
    ack_vec[DCG_REG]   = dcg_ack_i;
  end

  assign sys_rdata_o = rdata_vec[region];
  assign sys_ack_o   = |(cs & ack_vec);
  assign sys_err_o   = |(cs & err_vec);  // no slave reports errors

endmodule

`default_nettype wire

//--- hw/rp_top.sv
/*
 * Analog core top level
 * bus decoder, housekeeping and dc level registers,
 * ADC front end and DAC back end on adc_clk
 */

`timescale 1ns/10ps
`default_nettype none

`include "rp_defs.svh"

module rp_top (
  input  wire                     adc_clk,
  input  wire                     rst_n_i,
  // ADC
  input  wire [`RP_ADC_PIN_W-1:0] adc_dat_a_i,
  input  wire [`RP_ADC_PIN_W-1:0] adc_dat_b_i,
  // system bus
  input  wire rp_pkg::bus_word_t  sys_addr_i,
  input  wire rp_pkg::bus_word_t  sys_wdata_i,
  input  wire                     sys_wen_i,
  input  wire                     sys_ren_i,
  output rp_pkg::bus_word_t       sys_rdata_o,
  output logic                    sys_err_o,
  output logic                    sys_ack_o,
  // DAC
  output logic [`RP_SMP_W-1:0]    dac_dat_a_o,
  output logic [`RP_SMP_W-1:0]    dac_dat_b_o,
  // LEDs, expansion connector
  output logic [`RP_LED_W-1:0]    led_o,
  input  wire [`RP_EXP_W-1:0]     exp_p_dat_i,
  input  wire [`RP_EXP_W-1:0]     exp_n_dat_i,
  output logic [`RP_EXP_W-1:0]    exp_p_dat_o,
  output logic [`RP_EXP_W-1:0]    exp_n_dat_o,
  output logic [`RP_EXP_W-1:0]    exp_p_dir_o,
  output logic [`RP_EXP_W-1:0]    exp_n_dir_o
);

  // bus slaves
  logic              hk_wen, hk_ren, hk_ack;
  logic              dcg_wen, dcg_ren, dcg_ack;
  rp_pkg::bus_word_t hk_rdata, dcg_rdata;

  // analog path
  logic              digital_loop;
  logic [1:0]        fb_en;
  rp_pkg::smp_t      level_a, level_b;
  rp_pkg::smp_t      adc_a, adc_b;      // signed ADC or loopback
  rp_pkg::smp_t      dac_a, dac_b;      // registered DAC value

  rp_sys_bus_mux i_bus_mux (
    .sys_addr_i  (sys_addr_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .hk_rdata_i  (hk_rdata),
    .dcg_rdata_i (dcg_rdata),
    .hk_ack_i    (hk_ack),
    .dcg_ack_i   (dcg_ack),
    .hk_wen_o    (hk_wen),
    .hk_ren_o    (hk_ren),
    .dcg_wen_o   (dcg_wen),
    .dcg_ren_o   (dcg_ren),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .sys_err_o   (sys_err_o)
  );

  rp_housekeeping i_hk (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .sys_addr_i     (sys_addr_i),
    .sys_wdata_i    (sys_wdata_i),
    .sys_wen_i      (hk_wen),        // region 0
    .sys_ren_i      (hk_ren),
    .exp_p_dat_i    (exp_p_dat_i),
    .exp_n_dat_i    (exp_n_dat_i),
    .sys_rdata_o    (hk_rdata),
    .sys_ack_o      (hk_ack),
    .led_o          (led_o),
    .exp_p_dat_o    (exp_p_dat_o),
    .exp_n_dat_o    (exp_n_dat_o),
    .exp_p_dir_o    (exp_p_dir_o),
    .exp_n_dir_o    (exp_n_dir_o),
    .digital_loop_o (digital_loop)
  );

  rp_dc_gen i_dcg (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (dcg_wen),           // region 2
    .sys_ren_i   (dcg_ren),
    .sys_rdata_o (dcg_rdata),
    .sys_ack_o   (dcg_ack),
    .level_a_o   (level_a),
    .level_b_o   (level_b),
    .fb_en_o     (fb_en)
  );

  ////////////////////
  // analog path
  ////////////////////

  rp_adc_frontend i_adc (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .adc_dat_a_i    (adc_dat_a_i),
    .adc_dat_b_i    (adc_dat_b_i),
    .digital_loop_i (digital_loop),
    .loop_a_i       (dac_a),          // registered, no comb loop
    .loop_b_i       (dac_b),
    .adc_a_o        (adc_a),
    .adc_b_o        (adc_b)
  );

  rp_dac_backend i_dac (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .level_a_i   (level_a),
    .level_b_i   (level_b),
    .adc_a_i     (adc_a),
    .adc_b_i     (adc_b),
    .fb_en_i     (fb_en),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o),
    .dac_a_o     (dac_a),
    .dac_b_o     (dac_b)
  );

endmodule

`default_nettype wire

//--- include/rp_defs.svh
/*
 * Analog board core definitions
 * widths, bus region decode, register offsets and reset codes
 */

`ifndef RP_DEFS_SVH
`define RP_DEFS_SVH

// data path widths
`define RP_SMP_W        14            // sample width
`define RP_ADC_PIN_W    16            // ADC pins, low 2 bits unused
`define RP_BUS_W        32            // bus address / data
`define RP_EXP_W        8             // expansion connector
`define RP_LED_W        8

// bus region decode
`define RP_REGIONS      8
`define RP_REG_SEL_HI   22
`define RP_REG_SEL_LO   20

// housekeeping offsets, addr[19:0]
`define RP_HK_ID_OFS        20'h00000
`define RP_HK_DLOOP_OFS     20'h00004  // bit 0
`define RP_HK_EXP_P_DIR_OFS 20'h00010
`define RP_HK_EXP_N_DIR_OFS 20'h00014
`define RP_HK_EXP_P_OUT_OFS 20'h00018
`define RP_HK_EXP_N_OUT_OFS 20'h0001C
`define RP_HK_EXP_P_IN_OFS  20'h00020  // read only
`define RP_HK_EXP_N_IN_OFS  20'h00024  // read only
`define RP_HK_LED_OFS       20'h00030

// dc level generator offsets
`define RP_DCG_LVL_A_OFS    20'h00000
`define RP_DCG_LVL_B_OFS    20'h00004
`define RP_DCG_FB_EN_OFS    20'h00008  // bits 1..0

`define RP_HK_ID        32'h0001_2014
`define RP_DAC_RST_CODE 14'h1FFF       // pin code of signed zero

`endif

//--- testbench/tb_rp_top.sv
/*
 * Testbench for the analog core top level
 * bus register access, idle regions, ADC to DAC
 * feed-through, saturation and digital loop growth
 */

`timescale 1ns/10ps
`default_nettype none

`include "rp_defs.svh"

module tb_rp_top;

  localparam int CLK_HALF   = 20;              // 40 ns period
  localparam int ACK_WAIT   = 4;               // cycles before a missing ack is reported
  localparam int MAX_CYCLES = 2000;            // tests need about 350 cycles
  localparam int SMP_MAX    = 2 ** (`RP_SMP_W - 1) - 1;
  localparam int SMP_MIN    = -(2 ** (`RP_SMP_W - 1));
  localparam rp_pkg::bus_word_t HK_BASE  = 32'h0000_0000;  // region 0
  localparam rp_pkg::bus_word_t DCG_BASE = 32'h0020_0000;  // region 2

  logic                     adc_clk = 1'b0;
  logic                     rst_n_i;
  logic [`RP_ADC_PIN_W-1:0] adc_dat_a_i;
  logic [`RP_ADC_PIN_W-1:0] adc_dat_b_i;
  rp_pkg::bus_word_t        sys_addr_i;
  rp_pkg::bus_word_t        sys_wdata_i;
  logic                     sys_wen_i;
  logic                     sys_ren_i;
  rp_pkg::bus_word_t        sys_rdata_o;
  logic                     sys_err_o;
  logic                     sys_ack_o;
  logic [`RP_SMP_W-1:0]     dac_dat_a_o;
  logic [`RP_SMP_W-1:0]     dac_dat_b_o;
  logic [`RP_LED_W-1:0]     led_o;
  logic [`RP_EXP_W-1:0]     exp_p_dat_i;
  logic [`RP_EXP_W-1:0]     exp_n_dat_i;
  logic [`RP_EXP_W-1:0]     exp_p_dat_o;
  logic [`RP_EXP_W-1:0]     exp_n_dat_o;
  logic [`RP_EXP_W-1:0]     exp_p_dir_o;
  logic [`RP_EXP_W-1:0]     exp_n_dir_o;

  int                errors = 0;
  int                checks = 0;
  int                cycles = 0;
  logic [31:0]       lfsr_state = 32'h58cd_9faa;
  rp_pkg::bus_word_t rd;
  rp_pkg::bus_word_t wval;
  rp_pkg::bus_word_t port;
  int                lvl_a;
  int                lvl_b;
  int                mdl_a;
  int                mdl_b;
  logic [2:0]        region;
  logic [13:0]       exp_a [$];
  logic [13:0]       exp_b [$];
  int                idle_regions [6] = '{1, 3, 4, 5, 6, 7};
  rp_pkg::bus_word_t hk_ofs [5] = '{`RP_HK_LED_OFS, `RP_HK_EXP_P_DIR_OFS, `RP_HK_EXP_N_DIR_OFS,
                                    `RP_HK_EXP_P_OUT_OFS, `RP_HK_EXP_N_OUT_OFS};
  string             hk_port [5] = '{"led_o", "exp_p_dir_o", "exp_n_dir_o",
                                     "exp_p_dat_o", "exp_n_dat_o"};

  rp_top UUT (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_err_o   (sys_err_o),
    .sys_ack_o   (sys_ack_o),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o),
    .led_o       (led_o),
    .exp_p_dat_i (exp_p_dat_i),
    .exp_n_dat_i (exp_n_dat_i),
    .exp_p_dat_o (exp_p_dat_o),
    .exp_n_dat_o (exp_n_dat_o),
    .exp_p_dir_o (exp_p_dir_o),
    .exp_n_dir_o (exp_n_dir_o)
  );

  always #(CLK_HALF) adc_clk = ~adc_clk;

  // run limit
  always @(posedge adc_clk)
  begin
    cycles++;
    if (cycles > MAX_CYCLES)
    begin
      $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // err must stay low in every cycle
  assert property (@(negedge adc_clk) disable iff (!rst_n_i) sys_err_o === 1'b0)
  else
  begin
    errors++;
    $display("[FAIL] sys_err_o: expected 0x0, got 0x%h", sys_err_o);
  end

  ////////////////////
  // helpers
  ////////////////////

  // x^32 + x^22 + x^2 + x + 1, right shifting
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'h8020_0003;
    return s >> 1;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++)
    begin
      lfsr_state = lfsr_step(lfsr_state);  // one step per bit
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic int sat_sum(input int a, input int b);
    int s;
    s = a + b;
    if (s > SMP_MAX)
      s = SMP_MAX;
    else if (s < SMP_MIN)
      s = SMP_MIN;
    return s;
  endfunction

  // signed value -> pin code, lower 13 bits flip
  function automatic logic [13:0] to_code(input int v);
    logic [13:0] t;
    t = v[13:0];
    return t ^ 14'h1FFF;
  endfunction

  // adc pins -> signed sample
  function automatic int pin_value(input logic [15:0] pin);
    logic [13:0] t;
    t = pin[15:2] ^ 14'h1FFF;
    return int'($signed(t));
  endfunction

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp)
    else
    begin
      errors++;
      $display("[FAIL] %s: expected 0x%h, got 0x%h", name, exp, act);
    end
  endtask

  task automatic require(input logic cond, input string what);
    checks++;
    assert (cond === 1'b1)
    else
    begin
      errors++;
      $display("error: %s", what);
    end
  endtask

  // one pulse, address held until ack, latency counted in cycles
  task automatic bus_access(input logic wr, input rp_pkg::bus_word_t addr,
                            input rp_pkg::bus_word_t wdata, input int exp_lat,
                            output rp_pkg::bus_word_t rdata);
    int lat;
    lat = 0;
    @(negedge adc_clk);
    sys_addr_i  = addr;
    sys_wdata_i = wdata;
    sys_wen_i   = wr;
    sys_ren_i   = ~wr;
    #(CLK_HALF / 2);  // sample mid low phase
    while (sys_ack_o !== 1'b1 && lat < ACK_WAIT)
    begin
      @(negedge adc_clk);
      sys_wen_i = 1'b0;
      sys_ren_i = 1'b0;
      lat++;
      #(CLK_HALF / 2);
    end
    require(sys_ack_o === 1'b1, "bus transaction was never acknowledged");
    compare("sys_ack_o latency", exp_lat, lat);
    compare("sys_err_o", 32'h0, sys_err_o);
    rdata = sys_rdata_o;
    if (lat == 0)
    begin
      @(negedge adc_clk);  // same cycle ack, pulse still up
      sys_wen_i = 1'b0;
      sys_ren_i = 1'b0;
    end
  endtask

  task automatic write_reg(input rp_pkg::bus_word_t addr, input rp_pkg::bus_word_t data,
                           input int exp_lat);
    rp_pkg::bus_word_t unused;
    bus_access(1'b1, addr, data, exp_lat, unused);
  endtask

  task automatic read_reg(input rp_pkg::bus_word_t addr, input int exp_lat,
                          output rp_pkg::bus_word_t data);
    bus_access(1'b0, addr, '0, exp_lat, data);
  endtask

  ////////////////////
  // test sequence
  ////////////////////

  initial
  begin
    rst_n_i     = 1'b0;
    adc_dat_a_i = '0;
    adc_dat_b_i = '0;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    exp_p_dat_i = '0;
    exp_n_dat_i = '0;
    repeat (5) @(negedge adc_clk);
    rst_n_i = 1'b1;

    // reset state of the DAC
    compare("dac_dat_a_o", `RP_DAC_RST_CODE, dac_dat_a_o);
    compare("dac_dat_b_o", `RP_DAC_RST_CODE, dac_dat_b_o);

    // housekeeping registers
    read_reg(HK_BASE | `RP_HK_ID_OFS, 1, rd);
    compare("sys_rdata_o", `RP_HK_ID, rd);
    for (int i = 0; i < 5; i++)
    begin
      wval = rand_bits(32);  // upper bits must be dropped
      write_reg(HK_BASE | hk_ofs[i], wval, 1);
      case (i)
        0       : port = led_o;
        1       : port = exp_p_dir_o;
        2       : port = exp_n_dir_o;
        3       : port = exp_p_dat_o;
        default : port = exp_n_dat_o;
      endcase
      compare(hk_port[i], wval[7:0], port);
      read_reg(HK_BASE | hk_ofs[i], 1, rd);
      compare("sys_rdata_o", wval[7:0], rd);
    end
    write_reg(HK_BASE | `RP_HK_DLOOP_OFS, 32'h1, 1);
    read_reg(HK_BASE | `RP_HK_DLOOP_OFS, 1, rd);
    compare("sys_rdata_o", 32'h1, rd);
    write_reg(HK_BASE | `RP_HK_DLOOP_OFS, 32'h0, 1);

    // expansion inputs
    for (int i = 0; i < 3; i++)
    begin
      @(negedge adc_clk);
      exp_p_dat_i = rand_bits(8);
      exp_n_dat_i = rand_bits(8);
      read_reg(HK_BASE | `RP_HK_EXP_P_IN_OFS, 1, rd);
      compare("sys_rdata_o", exp_p_dat_i, rd);
      read_reg(HK_BASE | `RP_HK_EXP_N_IN_OFS, 1, rd);
      compare("sys_rdata_o", exp_n_dat_i, rd);
    end

    // idle regions answer in the pulse cycle
    for (int i = 0; i < 6; i++)
    begin
      region = idle_regions[i][2:0];
      wval   = rand_bits(18);
      read_reg({9'h0, region, wval[17:0], 2'b00}, 0, rd);
      compare("sys_rdata_o", 32'h0, rd);
    end
    write_reg(32'h0010_0000, rand_bits(32), 0);
    read_reg(HK_BASE | 32'h40, 1, rd);  // unmapped offset
    compare("sys_rdata_o", 32'h0, rd);
    read_reg(HK_BASE | 32'h3C, 1, rd);
    compare("sys_rdata_o", 32'h0, rd);

    // feed-through, batch 0 has level zero
    write_reg(DCG_BASE | `RP_DCG_FB_EN_OFS, 32'h3, 1);
    read_reg(DCG_BASE | `RP_DCG_FB_EN_OFS, 1, rd);
    compare("sys_rdata_o", 32'h3, rd);
    for (int b = 0; b < 4; b++)
    begin
      lvl_a = (b == 0) ? 0 : int'(rand_bits(10)) - 512;
      lvl_b = (b == 0) ? 0 : int'(rand_bits(10)) - 512;
      write_reg(DCG_BASE | `RP_DCG_LVL_A_OFS, 32'(lvl_a), 1);
      write_reg(DCG_BASE | `RP_DCG_LVL_B_OFS, 32'(lvl_b), 1);
      read_reg(DCG_BASE | `RP_DCG_LVL_A_OFS, 1, rd);  // sign extended level
      compare("sys_rdata_o", 32'(lvl_a), rd);
      read_reg(DCG_BASE | `RP_DCG_LVL_B_OFS, 1, rd);
      compare("sys_rdata_o", 32'(lvl_b), rd);
      for (int i = 0; i < 22; i++)
      begin
        @(negedge adc_clk);
        if (i >= 2)
        begin
          compare("dac_dat_a_o", exp_a.pop_front(), dac_dat_a_o);
          compare("dac_dat_b_o", exp_b.pop_front(), dac_dat_b_o);
        end
        if (i < 20)
        begin
          adc_dat_a_i = rand_bits(16);
          adc_dat_b_i = rand_bits(16);
          if (b == 0)
          begin
            exp_a.push_back(adc_dat_a_i[15:2]);  // code passes straight through
            exp_b.push_back(adc_dat_b_i[15:2]);
          end
          else
          begin
            exp_a.push_back(to_code(sat_sum(lvl_a, pin_value(adc_dat_a_i))));
            exp_b.push_back(to_code(sat_sum(lvl_b, pin_value(adc_dat_b_i))));
          end
        end
      end
    end

    // saturation both ways, channels swapped on the second pass
    for (int p = 0; p < 2; p++)
    begin
      write_reg(DCG_BASE | `RP_DCG_LVL_A_OFS, (p == 0) ? 32'(SMP_MAX) : 32'(SMP_MIN), 1);
      write_reg(DCG_BASE | `RP_DCG_LVL_B_OFS, (p == 0) ? 32'(SMP_MIN) : 32'(SMP_MAX), 1);
      @(negedge adc_clk);
      adc_dat_a_i = (p == 0) ? 16'h0000 : 16'hFFFF;  // +full / -full scale
      adc_dat_b_i = (p == 0) ? 16'hFFFF : 16'h0000;
      repeat (3) @(negedge adc_clk);
      compare("dac_dat_a_o", (p == 0) ? 14'h0000 : 14'h3FFF, dac_dat_a_o);
      compare("dac_dat_b_o", (p == 0) ? 14'h3FFF : 14'h0000, dac_dat_b_o);
    end

    ////////////////////
    // digital loop
    ////////////////////

    lvl_a = 300 + int'(rand_bits(9));
    lvl_b = -(300 + int'(rand_bits(9)));
    write_reg(DCG_BASE | `RP_DCG_FB_EN_OFS, 32'h0, 1);
    write_reg(HK_BASE | `RP_HK_DLOOP_OFS, 32'h1, 1);
    write_reg(DCG_BASE | `RP_DCG_LVL_A_OFS, 32'(lvl_a), 1);
    write_reg(DCG_BASE | `RP_DCG_LVL_B_OFS, 32'(lvl_b), 1);
    write_reg(DCG_BASE | `RP_DCG_FB_EN_OFS, 32'h3, 1);
    mdl_a = lvl_a;  // dac holds the level when feedback turns on
    mdl_b = lvl_b;
    for (int i = 0; i < 40; i++)
    begin
      @(negedge adc_clk);
      mdl_a = sat_sum(lvl_a, mdl_a);
      mdl_b = sat_sum(lvl_b, mdl_b);
      compare("dac_dat_a_o", to_code(mdl_a), dac_dat_a_o);
      compare("dac_dat_b_o", to_code(mdl_b), dac_dat_b_o);
    end
    require(mdl_a == SMP_MAX && mdl_b == SMP_MIN, "loop model did not reach saturation");
    write_reg(HK_BASE | `RP_HK_DLOOP_OFS, 32'h0, 1);

    $display("checks: %0d, errors: %0d, cycles: %0d", checks, errors, cycles);
    if (errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+include
hw/rp_pkg.sv
hw/rp_sys_bus_mux.sv
hw/rp_housekeeping.sv
hw/rp_dc_gen.sv
hw/rp_adc_frontend.sv
hw/rp_dac_backend.sv
hw/rp_top.sv
testbench/tb_rp_top.sv
